/* logic/bk_sys_pkg.sv */
// BK0011M system register and port block shared definitions
// Register offsets, bit positions, widths and reset values
package bk_sys_pkg;

	//////////////////////////////////////////////////////////
	// Widths and types
	//////////////////////////////////////////////////////////
	localparam int WORD_W   = 16;
	localparam int SAMPLE_W = 16;
	localparam int SPK_W    = 3;
	localparam int ADDR_W   = 4;

	typedef logic [WORD_W-1:0]   word_t;
	typedef logic [SAMPLE_W-1:0] sample_t;
	typedef logic [SPK_W-1:0]    spk_t;
	typedef logic [ADDR_W-1:0]   addr_t;

	//////////////////////////////////////////////////////////
	// Register map
	//////////////////////////////////////////////////////////
	// Port register, 177714 octal
	localparam addr_t ADDR_PORT   = 4'd0;
	// System register, 177716 octal
	localparam addr_t ADDR_SYSREG = 4'd2;

	// System register write fields
	localparam int SYS_SPK0_BIT  = 2;
	localparam int SYS_SPK1_BIT  = 5;
	localparam int SYS_SPK2_BIT  = 6;
	localparam int SYS_GUARD_BIT = 11;
	localparam int SYS_BLOCK_BIT = 12;

	// System register read fields
	localparam int SYS_SUPER_BIT = 2;
	localparam int SYS_KEYUP_BIT = 6;
	localparam int SYS_ONE_BIT   = 7;
	localparam int START_LSB     = 8;

	// Reset values
	localparam spk_t    SPK_RST    = '0;
	localparam word_t   COVOX_RST  = '0;
	localparam sample_t SAMPLE_RST = '0;

endpackage

/* logic/bk_apb_decode.sv */
// APB slave decode for the system and port registers
// Turns address and phase into selects, byte lanes and an access pulse
module bk_apb_decode (
	input  logic               psel_i,
	input  logic               penable_i,
	input  logic               pwrite_i,
	input  bk_sys_pkg::addr_t  paddr_i,
	input  logic [1:0]         pstrb_i,
	input  bk_sys_pkg::word_t  rd_data_i,
	output logic               acc_go_o,
	output logic               acc_port_o,
	output logic               acc_sys_o,
	output logic               wr_en_o,
	output logic               lane_lo_o,
	output logic               lane_hi_o,
	output logic               pready_o,
	output logic               pslverr_o,
	output bk_sys_pkg::word_t  prdata_o
);
	import bk_sys_pkg::*;

	logic acc_phase;
	logic hit_port;
	logic hit_sys;

	// Second cycle of a transfer
	assign acc_phase = psel_i & penable_i;

	assign hit_port = (paddr_i == ADDR_PORT);
	assign hit_sys  = (paddr_i == ADDR_SYSREG);

	////////////////////////////////////////////////////////////
	// Register side
	////////////////////////////////////////////////////////////
	assign acc_go_o   = acc_phase;
	assign acc_port_o = acc_phase & hit_port;
	assign acc_sys_o  = acc_phase & hit_sys;
	assign wr_en_o    = acc_phase & pwrite_i;

	// Strobe bit 0 is the low byte, bit 1 the high byte
	assign lane_lo_o = pstrb_i[0];
	assign lane_hi_o = pstrb_i[1];

	////////////////////////////////////////////////////////////
	// Bus side
	////////////////////////////////////////////////////////////
	// No wait states
	assign pready_o  = acc_phase;
	assign pslverr_o = acc_phase & ~(hit_port | hit_sys);

	always_comb begin
		if (pslverr_o) begin
			prdata_o = '0;
		end else begin
			prdata_o = rd_data_i;
		end
	end

endmodule

/* logic/bk_sys_regs.sv */
// System register 177716 and port register 177714
// Speaker bits, STOP block, supervisor flag, Covox word and read data
module bk_sys_regs (
	input  logic               clk_sys,
	input  logic               arst_n_i,
	input  logic               acc_go_i,
	input  logic               acc_port_i,
	input  logic               acc_sys_i,
	input  logic               wr_en_i,
	input  logic               lane_lo_i,
	input  logic               lane_hi_i,
	input  logic               key_down_i,
	input  logic               key_stop_i,
	input  logic               bk0010_i,
	input  bk_sys_pkg::word_t  wdata_i,
	input  logic [7:0]         start_page_i,
	input  logic [7:0]         joystick_i,
	output bk_sys_pkg::word_t  rd_data_o,
	output bk_sys_pkg::spk_t   spk_o,
	output bk_sys_pkg::word_t  covox_o,
	output logic               stop_irq_o
);
	import bk_sys_pkg::*;

	logic  sys_acc;
	logic  sys_wr;
	logic  port_wr;
	logic  spk_upd;
	logic  block_upd;
	logic  block_q;
	logic  super_q;
	spk_t  spk_q;
	word_t covox_q;

	assign sys_acc = acc_go_i & acc_sys_i;
	assign sys_wr  = sys_acc & wr_en_i;
	assign port_wr = acc_go_i & acc_port_i & wr_en_i;

	// With the high lane on, bit 11 guards both speaker and block fields
	assign spk_upd   = sys_wr & lane_lo_i & (~lane_hi_i | ~wdata_i[SYS_GUARD_BIT]);
	assign block_upd = sys_wr & lane_hi_i & ~wdata_i[SYS_GUARD_BIT];

	////////////////////////////////////////////////////////////
	// System register state
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys or negedge arst_n_i) begin
		if (!arst_n_i) begin
			spk_q   <= SPK_RST;
			block_q <= 1'b0;
			super_q <= 1'b0;
		end else begin
			if (spk_upd) begin
				// BK0010 has no speaker bit 0
				spk_q <= {wdata_i[SYS_SPK2_BIT],
				          wdata_i[SYS_SPK1_BIT],
				          wdata_i[SYS_SPK0_BIT] & ~bk0010_i};
			end
			if (block_upd) begin
				block_q <= wdata_i[SYS_BLOCK_BIT];
			end
			// Set on write, cleared on read
			if (sys_acc) begin
				super_q <= wr_en_i;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Covox latch, byte by byte
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys or negedge arst_n_i) begin
		if (!arst_n_i) begin
			covox_q <= COVOX_RST;
		end else if (port_wr) begin
			if (lane_lo_i) begin
				covox_q[7:0] <= wdata_i[7:0];
			end
			if (lane_hi_i) begin
				covox_q[15:8] <= wdata_i[15:8];
			end
		end
	end

	// Read word, super flag shows the value before this access
	always_comb begin
		rd_data_o = '0;
		if (acc_sys_i) begin
			rd_data_o[WORD_W-1:START_LSB] = start_page_i;
			rd_data_o[SYS_ONE_BIT]        = 1'b1;
			rd_data_o[SYS_KEYUP_BIT]      = ~key_down_i;
			rd_data_o[SYS_SUPER_BIT]      = super_q;
		end else if (acc_port_i) begin
			rd_data_o = {{(WORD_W-8){1'b0}}, joystick_i};
		end
	end

	assign spk_o   = spk_q;
	assign covox_o = covox_q;

	// STOP key reaches the CPU only while unblocked
	assign stop_irq_o = key_stop_i & ~block_q;

endmodule

/* logic/bk_audio_mix.sv */
// Audio mixer for speaker bits and Covox bytes
// Builds registered left and right 16-bit samples
module bk_audio_mix (
	input  logic                 clk_sys,
	input  logic                 arst_n_i,
	input  logic                 covox_en_i,
	input  bk_sys_pkg::spk_t     spk_i,
	input  bk_sys_pkg::word_t    covox_i,
	output bk_sys_pkg::sample_t  sample_l_o,
	output bk_sys_pkg::sample_t  sample_r_o
);
	import bk_sys_pkg::*;

	sample_t spk_low;
	sample_t spk_high;
	sample_t mix_l;
	sample_t mix_r;

	// Speaker under the Covox level, or alone at full scale
	assign spk_low  = {2'b00, spk_i, 11'd0};
	assign spk_high = {spk_i, 13'd0};

	////////////////////////////////////////////////////////////
	// Channel mix
	////////////////////////////////////////////////////////////
	always_comb begin
		if (covox_en_i) begin
			// Byte in 14:7, repeated top bits fill 6:0
			mix_l = {1'b0, covox_i[7:0], covox_i[7:1]} + spk_low;
			mix_r = {1'b0, covox_i[15:8], covox_i[15:9]} + spk_low;
		end else begin
			mix_l = spk_high;
			mix_r = spk_high;
		end
	end

	always_ff @(posedge clk_sys or negedge arst_n_i) begin
		if (!arst_n_i) begin
			sample_l_o <= SAMPLE_RST;
			sample_r_o <= SAMPLE_RST;
		end else begin
			sample_l_o <= mix_l;
			sample_r_o <= mix_r;
		end
	end

endmodule

/* logic/bk_sd_dac.sv */
// First-order sigma-delta DAC for one audio channel
// Carry out of the accumulator is the one-bit stream
module bk_sd_dac (
	input  logic                 clk_sys,
	input  logic                 arst_n_i,
	input  bk_sys_pkg::sample_t  sample_i,
	output logic                 bit_o
);
	import bk_sys_pkg::*;

	logic [SAMPLE_W:0] acc_q;

	// Carry is dropped back out on every add
	always_ff @(posedge clk_sys or negedge arst_n_i) begin
		if (!arst_n_i) begin
			acc_q <= '0;
		end else begin
			acc_q <= {1'b0, acc_q[SAMPLE_W-1:0]} + {1'b0, sample_i};
		end
	end

	assign bit_o = acc_q[SAMPLE_W];

endmodule

/* logic/bk_sysport_top.sv */
// BK0011M system and port registers on APB with Covox audio path
// Decode, register file, mixer and a sigma-delta DAC per channel
module bk_sysport_top (
	input  logic                 clk_sys,
	input  logic                 arst_n_i,
	input  logic                 psel_i,
	input  logic                 penable_i,
	input  logic                 pwrite_i,
	input  bk_sys_pkg::addr_t    paddr_i,
	input  bk_sys_pkg::word_t    pwdata_i,
	input  logic [1:0]           pstrb_i,
	output bk_sys_pkg::word_t    prdata_o,
	output logic                 pready_o,
	output logic                 pslverr_o,
	input  logic                 key_down_i,
	input  logic                 key_stop_i,
	input  logic                 bk0010_i,
	input  logic                 covox_en_i,
	input  logic [7:0]           start_page_i,
	input  logic [7:0]           joystick_i,
	output logic                 stop_irq_o,
	output bk_sys_pkg::sample_t  sample_l_o,
	output bk_sys_pkg::sample_t  sample_r_o,
	output logic                 audio_l_o,
	output logic                 audio_r_o
);
	import bk_sys_pkg::*;

	logic  acc_go;
	logic  acc_port;
	logic  acc_sys;
	logic  wr_en;
	logic  lane_lo;
	logic  lane_hi;
	word_t rd_data;
	spk_t  spk;
	word_t covox_word;

	////////////////////////////////////////////////////////////
	// Bus and registers
	////////////////////////////////////////////////////////////
	bk_apb_decode decode0 (
		.psel_i     (psel_i),
		.penable_i  (penable_i),
		.pwrite_i   (pwrite_i),
		.paddr_i    (paddr_i),
		.pstrb_i    (pstrb_i),
		.rd_data_i  (rd_data),
		.acc_go_o   (acc_go),
		.acc_port_o (acc_port),
		.acc_sys_o  (acc_sys),
		.wr_en_o    (wr_en),
		.lane_lo_o  (lane_lo),
		.lane_hi_o  (lane_hi),
		.pready_o   (pready_o),
		.pslverr_o  (pslverr_o),
		.prdata_o   (prdata_o)
	);

	bk_sys_regs regs0 (
		.clk_sys      (clk_sys),
		.arst_n_i     (arst_n_i),
		.acc_go_i     (acc_go),
		.acc_port_i   (acc_port),
		.acc_sys_i    (acc_sys),
		.wr_en_i      (wr_en),
		.lane_lo_i    (lane_lo),
		.lane_hi_i    (lane_hi),
		.key_down_i   (key_down_i),
		.key_stop_i   (key_stop_i),
		.bk0010_i     (bk0010_i),
		.wdata_i      (pwdata_i),
		.start_page_i (start_page_i),
		.joystick_i   (joystick_i),
		.rd_data_o    (rd_data),
		.spk_o        (spk),
		.covox_o      (covox_word),
		.stop_irq_o   (stop_irq_o)
	);

	////////////////////////////////////////////////////////////
	// Audio
	////////////////////////////////////////////////////////////
	bk_audio_mix mix0 (
		.clk_sys    (clk_sys),
		.arst_n_i   (arst_n_i),
		.covox_en_i (covox_en_i),
		.spk_i      (spk),
		.covox_i    (covox_word),
		.sample_l_o (sample_l_o),
		.sample_r_o (sample_r_o)
	);

	bk_sd_dac dac_l (
		.clk_sys  (clk_sys),
		.arst_n_i (arst_n_i),
		.sample_i (sample_l_o),
		.bit_o    (audio_l_o)
	);

	bk_sd_dac dac_r (
		.clk_sys  (clk_sys),
		.arst_n_i (arst_n_i),
		.sample_i (sample_r_o),
		.bit_o    (audio_r_o)
	);

endmodule

/* verification/tb_clkgen.sv */
// Testbench clock and reset source
// Free-running clock, reset held low for a fixed number of cycles
module tb_clkgen #(
	parameter int PERIOD     = 20,
	parameter int RST_CYCLES = 10
) (
	output logic clk_o,
	output logic arst_n_o
);

	initial begin
		clk_o = 1'b0;
		forever begin
			#(PERIOD / 2);
			clk_o = ~clk_o;
		end
	end

	// Release away from the rising edge
	initial begin
		arst_n_o = 1'b0;
		repeat (RST_CYCLES) @(posedge clk_o);
		@(negedge clk_o);
		arst_n_o = 1'b1;
	end

endmodule

/* verification/tb_bk_sysport.sv */
// Directed testbench for the BK0011M system and port register block
// APB access, audio samples, STOP gating and DAC density
module tb_bk_sysport;
	import bk_sys_pkg::*;

	localparam int READY_TIMEOUT = 16;
	localparam int RESET_TIMEOUT = 100;

	logic       clk_sys;
	logic       arst_n_i;
	logic       psel_i;
	logic       penable_i;
	logic       pwrite_i;
	addr_t      paddr_i;
	word_t      pwdata_i;
	logic [1:0] pstrb_i;
	word_t      prdata_o;
	logic       pready_o;
	logic       pslverr_o;
	logic       key_down_i;
	logic       key_stop_i;
	logic       bk0010_i;
	logic       covox_en_i;
	logic [7:0] start_page_i;
	logic [7:0] joystick_i;
	logic       stop_irq_o;
	sample_t    sample_l_o;
	sample_t    sample_r_o;
	logic       audio_l_o;
	logic       audio_r_o;

	int     errors;
	int     err_mark;
	int     tests_run;
	int     tests_failed;
	integer seed;
	// Result of the last APB transfer
	word_t  rd_word;
	logic   rd_err;
	// Expected register state
	spk_t   spk_model;
	word_t  covox_model;

	tb_clkgen #(
		.PERIOD     (20),
		.RST_CYCLES (10)
	) clkgen0 (
		.clk_o    (clk_sys),
		.arst_n_o (arst_n_i)
	);

	bk_sysport_top dut0 (.*);

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////
	task automatic compare_word(input string name, input word_t got, input word_t expected);
		if (got !== expected) begin
			$display("MISMATCH %s got %h expected %h", name, got, expected);
			errors++;
		end
	endtask

	task automatic compare_sample(input string name, input sample_t got,
			input sample_t expected);
		if (got !== expected) begin
			$display("MISMATCH %s got %h expected %h", name, got, expected);
			errors++;
		end
	endtask

	task automatic compare_bit(input string name, input logic got, input logic expected);
		if (got !== expected) begin
			$display("MISMATCH %s got %h expected %h", name, got, expected);
			errors++;
		end
	endtask

	task automatic report_test(input string name);
		tests_run++;
		if (errors == err_mark) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: %0d errors", tests_run, name, errors - err_mark);
		end
		err_mark = errors;
	endtask

	////////////////////////////////////////////////////////////
	// Reference model and bus access
	////////////////////////////////////////////////////////////
	// Byte at weight 2^7, its top seven bits below, speaker at 2^11
	function automatic sample_t covox_sample(input logic [7:0] b, input spk_t spk);
		return (sample_t'(b) << 7) + (sample_t'(b) >> 1) + (sample_t'(spk) << 11);
	endfunction

	// One APB transfer, result left in rd_word and rd_err
	task automatic apb_access(input logic wr, input addr_t addr, input word_t data,
			input logic [1:0] strb);
		int n;
		@(posedge clk_sys);
		psel_i    <= 1'b1;
		penable_i <= 1'b0;
		pwrite_i  <= wr;
		paddr_i   <= addr;
		pwdata_i  <= data;
		pstrb_i   <= strb;
		@(posedge clk_sys);
		penable_i <= 1'b1;
		n = 0;
		@(negedge clk_sys);
		while (!pready_o && n < READY_TIMEOUT) begin
			@(negedge clk_sys);
			n++;
		end
		if (!pready_o) begin
			$display("pready_o stayed low for %0d cycles at address %h", READY_TIMEOUT, addr);
			errors++;
		end
		rd_word = prdata_o;
		rd_err  = pslverr_o;
		@(posedge clk_sys);
		psel_i    <= 1'b0;
		penable_i <= 1'b0;
	endtask

	// Samples follow one cycle after the register write
	task automatic check_samples(input sample_t exp_l, input sample_t exp_r);
		@(posedge clk_sys);
		@(negedge clk_sys);
		compare_sample("sample_l_o", sample_l_o, exp_l);
		compare_sample("sample_r_o", sample_r_o, exp_r);
		@(posedge clk_sys);
	endtask

	////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////
	task automatic test_sysreg_readback();
		// Reset state
		@(negedge clk_sys);
		compare_sample("sample_l_o", sample_l_o, '0);
		compare_sample("sample_r_o", sample_r_o, '0);
		compare_bit("pslverr_o", pslverr_o, 1'b0);
		@(posedge clk_sys);
		start_page_i <= 8'($random(seed));
		key_down_i   <= 1'b1;
		apb_access(1'b1, ADDR_SYSREG, 16'h0000, 2'b11);
		compare_bit("pslverr_o", rd_err, 1'b0);
		// Bit 7 one, key held, supervisor set by the write
		apb_access(1'b0, ADDR_SYSREG, 16'h0000, 2'b00);
		compare_word("prdata_o", rd_word, {start_page_i, 8'b1000_0100});
		key_down_i <= 1'b0;
		// The read cleared the supervisor flag
		apb_access(1'b0, ADDR_SYSREG, 16'h0000, 2'b00);
		compare_word("prdata_o", rd_word, {start_page_i, 8'b1100_0000});
		report_test("system register read-back");
	endtask

	task automatic test_speaker();
		word_t d;
		covox_en_i <= 1'b0;
		for (int i = 0; i < 8; i++) begin
			d = word_t'($random(seed));
			apb_access(1'b1, ADDR_SYSREG, d, 2'b01);
			spk_model = {d[6], d[5], d[2]};
			check_samples({spk_model, 13'd0}, {spk_model, 13'd0});
		end
		// BK0010 has no speaker bit 0
		bk0010_i <= 1'b1;
		apb_access(1'b1, ADDR_SYSREG, 16'h0064, 2'b01);
		spk_model = 3'b110;
		check_samples(16'hc000, 16'hc000);
		// Guard bit with both lanes leaves the speaker alone
		apb_access(1'b1, ADDR_SYSREG, 16'h0800, 2'b11);
		check_samples(16'hc000, 16'hc000);
		bk0010_i <= 1'b0;
		report_test("speaker samples");
	endtask

	task automatic test_covox();
		word_t      d;
		logic [1:0] strb;
		covox_en_i <= 1'b1;
		apb_access(1'b1, ADDR_SYSREG, 16'h0064, 2'b01);
		spk_model = 3'b111;
		for (int i = 0; i < 12; i++) begin
			d    = word_t'($random(seed));
			strb = 2'($random(seed));
			apb_access(1'b1, ADDR_PORT, d, strb);
			if (strb[0]) begin
				covox_model[7:0] = d[7:0];
			end
			if (strb[1]) begin
				covox_model[15:8] = d[15:8];
			end
			check_samples(covox_sample(covox_model[7:0], spk_model),
				covox_sample(covox_model[15:8], spk_model));
		end
		report_test("covox samples");
	endtask

	task automatic test_stop_block();
		key_stop_i <= 1'b1;
		@(negedge clk_sys);
		compare_bit("stop_irq_o", stop_irq_o, 1'b1);
		// High lane only, bit 12 sets the block flag
		apb_access(1'b1, ADDR_SYSREG, 16'h1000, 2'b10);
		@(negedge clk_sys);
		compare_bit("stop_irq_o", stop_irq_o, 1'b0);
		// Guard bit set, flag holds
		apb_access(1'b1, ADDR_SYSREG, 16'h0800, 2'b10);
		@(negedge clk_sys);
		compare_bit("stop_irq_o", stop_irq_o, 1'b0);
		apb_access(1'b1, ADDR_SYSREG, 16'h0000, 2'b10);
		@(negedge clk_sys);
		compare_bit("stop_irq_o", stop_irq_o, 1'b1);
		@(posedge clk_sys);
		key_stop_i <= 1'b0;
		@(negedge clk_sys);
		compare_bit("stop_irq_o", stop_irq_o, 1'b0);
		@(posedge clk_sys);
		report_test("STOP block");
	endtask

	task automatic test_port_and_errors();
		joystick_i <= 8'($random(seed));
		apb_access(1'b0, ADDR_PORT, 16'h0000, 2'b00);
		compare_word("prdata_o", rd_word, {8'h00, joystick_i});
		compare_bit("pslverr_o", rd_err, 1'b0);
		// Reads on even offsets, writes on odd ones
		for (int a = 0; a < 16; a++) begin
			if (addr_t'(a) != ADDR_PORT && addr_t'(a) != ADDR_SYSREG) begin
				apb_access(a[0], addr_t'(a), 16'hffff, 2'b11);
				compare_bit("pslverr_o", rd_err, 1'b1);
				compare_word("prdata_o", rd_word, '0);
			end
		end
		// Stray writes must not reach Covox word or speaker
		check_samples(covox_sample(covox_model[7:0], spk_model),
			covox_sample(covox_model[15:8], spk_model));
		report_test("port read and bad addresses");
	endtask

	task automatic check_density(input string name, input int ones, input sample_t level);
		int expected;
		expected = int'(level) * 2048 / 65536;
		if (ones < expected - 2 || ones > expected + 2) begin
			$display("%s gave %0d ones in 2048 cycles, expected %0d within 2",
				name, ones, expected);
			errors++;
		end
	endtask

	task automatic test_dac_density();
		int ones_l;
		int ones_r;
		apb_access(1'b1, ADDR_SYSREG, 16'h0000, 2'b01);
		spk_model = '0;
		apb_access(1'b1, ADDR_PORT, 16'hc35a, 2'b11);
		covox_model = 16'hc35a;
		check_samples(covox_sample(8'h5a, spk_model), covox_sample(8'hc3, spk_model));
		ones_l = 0;
		ones_r = 0;
		repeat (2048) begin
			@(negedge clk_sys);
			ones_l += int'(audio_l_o);
			ones_r += int'(audio_r_o);
		end
		check_density("audio_l_o", ones_l, covox_sample(8'h5a, spk_model));
		check_density("audio_r_o", ones_r, covox_sample(8'hc3, spk_model));
		report_test("DAC density");
	endtask

	task automatic wait_reset(output bit ok);
		int n;
		n = 0;
		while (arst_n_i !== 1'b1 && n < RESET_TIMEOUT) begin
			@(posedge clk_sys);
			n++;
		end
		ok = (arst_n_i === 1'b1);
	endtask

	initial begin
		bit reset_ok;
		errors       = 0;
		err_mark     = 0;
		tests_run    = 0;
		tests_failed = 0;
		seed         = 32'h8f6d_1400;
		spk_model    = '0;
		covox_model  = '0;
		psel_i       <= 1'b0;
		penable_i    <= 1'b0;
		pwrite_i     <= 1'b0;
		paddr_i      <= '0;
		pwdata_i     <= '0;
		pstrb_i      <= '0;
		key_down_i   <= 1'b0;
		key_stop_i   <= 1'b0;
		bk0010_i     <= 1'b0;
		covox_en_i   <= 1'b0;
		start_page_i <= '0;
		joystick_i   <= '0;
		wait_reset(reset_ok);
		if (reset_ok) begin
			test_sysreg_readback();
			test_speaker();
			test_covox();
			test_stop_block();
			test_port_and_errors();
			test_dac_density();
		end else begin
			$display("reset never released within %0d cycles", RESET_TIMEOUT);
			errors++;
		end
		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

/* all.f */
logic/bk_sys_pkg.sv
logic/bk_apb_decode.sv
logic/bk_sys_regs.sv
logic/bk_audio_mix.sv
logic/bk_sd_dac.sv
logic/bk_sysport_top.sv
verification/tb_clkgen.sv
verification/tb_bk_sysport.sv

/* run.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_bk_sysport -f all.f -o tb_sim \
	&& ./obj_dir/tb_sim | tee /dev/stderr | grep -q "ALL TESTS PASSED" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
